// ==== src/arb_config.svh ====
// Arbitration subsystem configuration: client count, counter and APB widths, priority direction.
`ifndef ARB_CONFIG_SVH
`define ARB_CONFIG_SVH

// Number of clients sharing the resource.
`define ARB_PORTS 4

// Width of each completed-grant counter.
`define ARB_CNT_W 16

// APB address and data bus widths.
`define APB_ADDR_W 8
`define APB_DATA_W 32

// 1 gives the lowest index the highest priority, 0 the highest index.
`define ARB_LSB_HIGH_PRIORITY 1

`endif

// ==== src/arb_pkg.sv ====
// Shared vector types for the arbitration subsystem and its testbench.
`include "arb_config.svh"

package arb_pkg;

    // One bit per client: request, acknowledge, grant and mask.
    typedef logic [`ARB_PORTS-1:0] port_vec_t;

    // Encoded client number.
    typedef logic [$clog2(`ARB_PORTS)-1:0] port_idx_t;

    // Completed-grant counter, saturating.
    typedef logic [`ARB_CNT_W-1:0] grant_cnt_t;

    // APB address and data words.
    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`APB_DATA_W-1:0] apb_data_t;

endpackage

// ==== src/priority_encoder.sv ====
// Combinational tree priority encoder giving valid, index and one-hot of the winning bit.
`timescale 1ns/1ps
`include "arb_config.svh"

module priority_encoder #(
    parameter int WIDTH = 4,
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0] input_unencoded,
    output logic             output_valid,
    output logic [IDX_W-1:0] output_encoded,
    output logic [WIDTH-1:0] output_unencoded
);

    localparam bit LSB_HIGH = `ARB_LSB_HIGH_PRIORITY;  // Direction of priority.
    localparam int W_PAD = 1 << IDX_W;                  // Leaves padded to a power of two.

    // Level 0 holds the leaves, level IDX_W the single root node.
    for (genvar l = 0; l <= IDX_W; l++) begin : g_lvl
        localparam int N = W_PAD >> l;                  // Nodes on this level.
        logic [N-1:0]            valid;                 // Any set bit below the node.
        logic [N-1:0][IDX_W-1:0] index;                 // Winning leaf below the node.

        if (l == 0) begin : g_leaf
            for (genvar k = 0; k < N; k++) begin : g_bit
                if (k < WIDTH) begin : g_in
                    assign valid[k] = input_unencoded[k];
                end else begin : g_pad
                    assign valid[k] = 1'b0;             // Padding leaf never wins.
                end
                assign index[k] = IDX_W'(k);            // Leaf carries its own position.
            end
        end else begin : g_merge
            for (genvar k = 0; k < N; k++) begin : g_node
                logic lo_valid;
                logic hi_valid;
                logic take_hi;
                assign lo_valid = g_lvl[l-1].valid[2*k];     // Lower-index half.
                assign hi_valid = g_lvl[l-1].valid[2*k+1];   // Upper-index half.
                assign take_hi  = LSB_HIGH ? !lo_valid : hi_valid;
                assign valid[k] = lo_valid | hi_valid;
                assign index[k] = take_hi ? g_lvl[l-1].index[2*k+1] : g_lvl[l-1].index[2*k];
            end
        end
    end

    assign output_valid     = g_lvl[IDX_W].valid[0];
    assign output_encoded   = g_lvl[IDX_W].index[0];
    // One-hot is zero when nothing is set.
    assign output_unencoded = output_valid ? (WIDTH'(1) << output_encoded) : '0;

endmodule

// ==== src/arbiter.sv ====
// Registered client arbiter, fixed or round robin, holding each grant until it is acknowledged.
`timescale 1ns/1ps
`include "arb_config.svh"

module arbiter import arb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  port_vec_t request,
    input  port_vec_t acknowledge,
    input  logic      arb_enable,
    input  logic      round_robin,
    input  port_vec_t port_mask,
    output port_vec_t grant,
    output logic      grant_valid,
    output port_idx_t grant_encoded,
    output port_vec_t grant_done
);

    localparam bit LSB_HIGH = `ARB_LSB_HIGH_PRIORITY;

    port_vec_t eligible;        // Requests that pass mask and enable.
    port_vec_t rr_mask;         // Ports preferred on the next round-robin pick.
    port_vec_t rr_mask_next;

    logic      plain_valid;
    port_idx_t plain_idx;
    port_vec_t plain_onehot;

    logic      masked_valid;
    port_idx_t masked_idx;
    port_vec_t masked_onehot;

    logic      hold;            // Grant still waiting for its acknowledge.
    port_idx_t pick_idx;
    port_vec_t pick_onehot;

    assign eligible   = arb_enable ? (request & port_mask) : '0;
    assign grant_done = grant_valid ? (grant & acknowledge) : '0;  // Same-cycle completion.
    assign hold       = grant_valid && (grant_done == '0);         // Back-pressure.

    // Plain winner over all eligible requests.
    priority_encoder #(
        .WIDTH(`ARB_PORTS)
    ) u_pe_plain (
        .input_unencoded (eligible),
        .output_valid    (plain_valid),
        .output_encoded  (plain_idx),
        .output_unencoded(plain_onehot)
    );

    // Winner among ports past the last grant.
    priority_encoder #(
        .WIDTH(`ARB_PORTS)
    ) u_pe_masked (
        .input_unencoded (eligible & rr_mask),
        .output_valid    (masked_valid),
        .output_encoded  (masked_idx),
        .output_unencoded(masked_onehot)
    );

    always_comb begin
        if (round_robin && masked_valid) begin
            pick_idx    = masked_idx;       // Next port after the last grant.
            pick_onehot = masked_onehot;
        end else begin
            pick_idx    = plain_idx;        // Fixed mode, or round robin wrapping around.
            pick_onehot = plain_onehot;
        end
        // Prefer the ports on the far side of the new grant next time.
        if (LSB_HIGH) begin
            rr_mask_next = {`ARB_PORTS{1'b1}} << (int'(pick_idx) + 1);
        end else begin
            rr_mask_next = {`ARB_PORTS{1'b1}} >> (`ARB_PORTS - int'(pick_idx));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant         <= '0;
            grant_valid   <= 1'b0;
            grant_encoded <= '0;
            rr_mask       <= '0;
        end else if (!hold) begin               // Idle, or acknowledged this cycle.
            if (plain_valid) begin
                grant         <= pick_onehot;
                grant_valid   <= 1'b1;
                grant_encoded <= pick_idx;
                rr_mask       <= rr_mask_next;  // Tracked in both modes.
            end else begin
                grant         <= '0;            // Nothing eligible.
                grant_valid   <= 1'b0;
                grant_encoded <= '0;
            end
        end
    end

endmodule

// ==== src/arb_regs.sv ====
// APB register block with arbiter control, port mask and per-port completed-grant counters.
`timescale 1ns/1ps
`include "arb_config.svh"

module arb_regs import arb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    input  port_vec_t grant_done,
    output logic      arb_enable,
    output logic      round_robin,
    output port_vec_t port_mask
);

    localparam apb_addr_t ADDR_CTRL = 'h00;   // Enable and mode.
    localparam apb_addr_t ADDR_MASK = 'h04;   // Per-port enable.
    localparam apb_addr_t ADDR_CNT0 = 'h08;   // First counter, one word per port.

    grant_cnt_t grant_cnt [`ARB_PORTS];       // Completed grants per port.

    logic      access;                        // APB access phase.
    logic      wr_en;
    logic      hit_ctrl;
    logic      hit_mask;
    port_vec_t hit_cnt;                       // One decode bit per counter.
    logic      mapped;
    apb_data_t rd_data;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    always_comb begin
        hit_ctrl = (paddr == ADDR_CTRL);
        hit_mask = (paddr == ADDR_MASK);
        for (int p = 0; p < `ARB_PORTS; p++) begin
            hit_cnt[p] = (paddr == apb_addr_t'(int'(ADDR_CNT0) + 4 * p));
        end
        mapped = hit_ctrl || hit_mask || (hit_cnt != '0);
    end

    // No wait states.
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;       // Unmapped address, nothing changes.

    always_comb begin
        rd_data = '0;
        if (hit_ctrl) begin
            rd_data = apb_data_t'({round_robin, arb_enable});
        end
        if (hit_mask) begin
            rd_data = apb_data_t'(port_mask);
        end
        for (int p = 0; p < `ARB_PORTS; p++) begin
            if (hit_cnt[p]) begin
                rd_data = apb_data_t'(grant_cnt[p]);
            end
        end
    end

    // Read data only during a read access.
    assign prdata = (access && !pwrite) ? rd_data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            arb_enable  <= 1'b0;
            round_robin <= 1'b0;
            port_mask   <= '1;                // All ports enabled.
        end else begin
            if (wr_en && hit_ctrl) begin
                arb_enable  <= pwdata[0];
                round_robin <= pwdata[1];
            end
            if (wr_en && hit_mask) begin
                port_mask <= pwdata[`ARB_PORTS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < `ARB_PORTS; p++) begin
                grant_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `ARB_PORTS; p++) begin
                if (wr_en && hit_cnt[p]) begin
                    grant_cnt[p] <= '0;                       // Write clears, beats increment.
                end else if (grant_done[p] && (grant_cnt[p] != '1)) begin
                    grant_cnt[p] <= grant_cnt[p] + 1'b1;      // Saturates at all ones.
                end
            end
        end
    end

endmodule

// ==== src/arb_subsys.sv ====
// Arbitration subsystem top: APB register block steering a four-client arbiter.
`timescale 1ns/1ps

module arb_subsys import arb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // APB slave.
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    // Client handshake.
    input  port_vec_t request,
    input  port_vec_t acknowledge,
    output port_vec_t grant,
    output logic      grant_valid,
    output port_idx_t grant_encoded
);

    logic      arb_enable;    // CTRL bit 0.
    logic      round_robin;   // CTRL bit 1.
    port_vec_t port_mask;     // MASK register.
    port_vec_t grant_done;    // Completed grant, for the counters.

    arb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .grant_done (grant_done),
        .arb_enable (arb_enable),
        .round_robin(round_robin),
        .port_mask  (port_mask)
    );

    arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .acknowledge  (acknowledge),
        .arb_enable   (arb_enable),
        .round_robin  (round_robin),
        .port_mask    (port_mask),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .grant_encoded(grant_encoded),
        .grant_done   (grant_done)
    );

endmodule

// ==== tb/arb_subsys_assert.sv ====
// Concurrent checks on grant encoding, hold and reset behaviour, bound to the subsystem top.
`timescale 1ns/1ps

module arb_subsys_assert import arb_pkg::*; (
    input logic      clk,
    input logic      rst,
    input port_vec_t acknowledge,
    input port_vec_t grant,
    input logic      grant_valid,
    input port_idx_t grant_encoded
);

    // At most one client holds the resource.
    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant has more than one bit set: %b", grant);

    // Index and one-hot agree while a grant is held.
    encoded_match: assert property (@(posedge clk) disable iff (rst)
        grant_valid |-> (grant == (port_vec_t'(1) << grant_encoded)))
        else $error("grant_encoded %0d does not match grant %b", grant_encoded, grant);

    // No stray grant bits when idle.
    idle_zero: assert property (@(posedge clk) disable iff (rst)
        !grant_valid |-> (grant == '0))
        else $error("grant %b set while grant_valid is low", grant);

    // Back-pressure: an unacknowledged grant is never dropped or moved.
    grant_hold: assert property (@(posedge clk) disable iff (rst)
        (grant_valid && ((grant & acknowledge) == '0)) |=> (grant_valid && $stable(grant)))
        else $error("held grant changed before its acknowledge");

    // Arbiter comes out of reset idle.
    reset_idle: assert property (@(posedge clk) rst |=> !grant_valid)
        else $error("grant_valid high in the cycle after reset");

endmodule

bind arb_subsys arb_subsys_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .acknowledge  (acknowledge),
    .grant        (grant),
    .grant_valid  (grant_valid),
    .grant_encoded(grant_encoded)
);

// ==== tb/tb_arb_subsys.sv ====
// Table-driven testbench for the arbitration subsystem with APB driver, grant model and checker.
`timescale 1ns/1ps
`include "arb_config.svh"

module tb_arb_subsys import arb_pkg::*; ();

    localparam int        PORTS     = `ARB_PORTS;
    localparam int        N_ROWS    = 8;
    localparam apb_addr_t ADDR_CTRL = 'h00;
    localparam apb_addr_t ADDR_MASK = 'h04;
    localparam apb_addr_t ADDR_CNT0 = 'h08;      // Counters follow with one word per port.
    localparam apb_addr_t ADDR_BAD  = 'h18;      // First word past the last counter.

    typedef struct packed {
        logic       rr;                          // Round robin when set.
        logic       en;                          // Arbiter enable.
        port_vec_t  mask;                        // MASK register value.
        port_vec_t  req;                         // Requests held for the row.
        port_vec_t  late;                        // Added while the first grant waits.
        logic [7:0] grants;                      // Grants to collect with none expected at 0.
    } row_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    port_vec_t request;
    port_vec_t acknowledge;
    port_vec_t grant;
    logic      grant_valid;
    port_idx_t grant_encoded;

    row_t        rows [N_ROWS];
    grant_cnt_t  model_cnt [PORTS];              // Acknowledged grants per port.
    int          last_idx;                       // Last granted port or -1 before any.
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          cycle_limit;

    arb_subsys UUT (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .request      (request),
        .acknowledge  (acknowledge),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .grant_encoded(grant_encoded)
    );

    always #5 clk = ~clk;                        // 100 MHz.

    // Run limit comes from the table before the first edge.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lowest eligible index in fixed mode, first eligible above the last grant in round robin.
    function automatic int predict_winner(input port_vec_t eligible, input logic rr,
                                          input int last);
        int start;
        start = (rr && last >= 0) ? last + 1 : 0;
        for (int i = start; i < PORTS; i++) begin
            if (eligible[i]) return i;
        end
        for (int i = 0; i < PORTS; i++) begin
            if (eligible[i]) return i;
        end
        return -1;                               // Nothing eligible.
    endfunction

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        #1;
        psel    = 1'b1;                          // Setup phase.
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;                          // Access phase.
        @(negedge clk);
        check_value("pready", pready, 1);
        check_value("pslverr", pslverr, 0);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_value("pready", pready, 1);
        data = prdata;                           // Combinational read data.
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input string name, input apb_addr_t addr, input apb_data_t exp);
        apb_data_t data;
        logic      err;
        apb_read(addr, data, err);
        check_value({name, " pslverr"}, err, 0);
        check_value(name, data, exp);
    endtask

    // Waits for one grant, checks it against the model, holds it, then acknowledges.
    task automatic run_grant(input row_t row, input bit first, input bit last);
        port_vec_t eligible;
        port_vec_t held;
        int        exp_idx;
        int        hold_cycles;
        @(negedge clk);
        while (!grant_valid) begin
            @(negedge clk);
        end
        eligible = row.en ? (request & row.mask) : '0;
        exp_idx  = predict_winner(eligible, row.rr, last_idx);
        check_value("grant_encoded", grant_encoded, exp_idx);
        check_value("grant", grant, 1 << exp_idx);
        last_idx = exp_idx;
        held     = grant;
        if (first) begin
            @(posedge clk);
            #1;
            request = request | row.late;        // Must not preempt the held grant.
            @(negedge clk);
            check_value("grant", grant, held);
        end
        rng_state   = xorshift32(rng_state);
        hold_cycles = int'(rng_state % 4);       // Acknowledge after 0 to 3 cycles.
        repeat (hold_cycles) begin
            @(negedge clk);
            check_value("grant", grant, held);
        end
        @(posedge clk);
        #1;
        acknowledge = held;
        if (last) begin
            request = '0;                        // Last grant of the row is not renewed.
        end
        model_cnt[exp_idx] = model_cnt[exp_idx] + 1'b1;
        @(posedge clk);
        #1;
        acknowledge = '0;
    endtask

    task automatic load_table();
        rows[0] = '{rr: 1'b0, en: 1'b1, mask: 4'hF, req: 4'b1110, late: 4'b0001, grants: 8'd4};
        rows[1] = '{rr: 1'b0, en: 1'b1, mask: 4'hF, req: 4'b1010, late: 4'b0000, grants: 8'd3};
        rows[2] = '{rr: 1'b1, en: 1'b1, mask: 4'hF, req: 4'b1111, late: 4'b0000, grants: 8'd6};
        rows[3] = '{rr: 1'b1, en: 1'b1, mask: 4'hF, req: 4'b1001, late: 4'b0110, grants: 8'd5};
        rows[4] = '{rr: 1'b1, en: 1'b1, mask: 4'h5, req: 4'b1111, late: 4'b0010, grants: 8'd4};
        rows[5] = '{rr: 1'b0, en: 1'b1, mask: 4'h6, req: 4'b1011, late: 4'b0100, grants: 8'd2};
        rows[6] = '{rr: 1'b0, en: 1'b0, mask: 4'hF, req: 4'b1111, late: 4'b0000, grants: 8'd0};
        rows[7] = '{rr: 1'b1, en: 1'b1, mask: 4'hC, req: 4'b1111, late: 4'b0000, grants: 8'd3};
    endtask

    initial begin
        apb_data_t data;
        logic      err;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        request     = '0;
        acknowledge = '0;
        rng_state   = 32'd70;
        last_idx    = -1;
        for (int p = 0; p < PORTS; p++) begin
            model_cnt[p] = '0;
        end
        load_table();
        cycle_limit = 200;
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit += 6 * int'(rows[r].grants);
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state.
        @(negedge clk);
        check_value("grant_valid", grant_valid, 0);
        check_value("grant", grant, 0);
        read_check("CTRL", ADDR_CTRL, 0);
        read_check("MASK", ADDR_MASK, 'hF);
        for (int p = 0; p < PORTS; p++) begin
            read_check("grant counter", apb_addr_t'(ADDR_CNT0 + 4 * p), 0);
        end
        apb_read(ADDR_BAD, data, err);
        check_value("pslverr", err, 1);          // Unmapped word.
        check_value("prdata", data, 0);

        for (int r = 0; r < N_ROWS; r++) begin
            apb_write(ADDR_CTRL, apb_data_t'({rows[r].rr, rows[r].en}));
            apb_write(ADDR_MASK, apb_data_t'(rows[r].mask));
            @(posedge clk);
            #1;
            request = rows[r].req;
            if (rows[r].grants == 0) begin
                repeat (8) begin
                    @(negedge clk);
                    check_value("grant_valid", grant_valid, 0);  // Disabled arbiter.
                end
            end
            for (int g = 0; g < int'(rows[r].grants); g++) begin
                run_grant(rows[r], g == 0, g == int'(rows[r].grants) - 1);
            end
            @(posedge clk);
            #1;
            request = '0;
        end

        // Counters against the model and a clearing write.
        for (int p = 0; p < PORTS; p++) begin
            read_check("grant counter", apb_addr_t'(ADDR_CNT0 + 4 * p), model_cnt[p]);
        end
        apb_write(apb_addr_t'(ADDR_CNT0 + 8), 'hFFFF_FFFF);
        model_cnt[2] = '0;
        read_check("grant counter 2", apb_addr_t'(ADDR_CNT0 + 8), 0);
        read_check("grant counter 3", apb_addr_t'(ADDR_CNT0 + 12), model_cnt[3]);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== arb_subsys.f ====
+incdir+src
src/arb_pkg.sv
src/priority_encoder.sv
src/arbiter.sv
src/arb_regs.sv
src/arb_subsys.sv
tb/arb_subsys_assert.sv
tb/tb_arb_subsys.sv

// ==== Makefile ====
# Verilator build and run of the arbitration subsystem testbench.

TOP := tb_arb_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f arb_subsys.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@! grep -q "Something failed" sim.log
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
